// ==== logic/sched_pkg.sv ====
// Scheduler dispatch package with widths, queue depth and the rename, entry and writeback types
`default_nettype none

package sched_pkg;

	// ==================================================
	// Pipeline widths
	// ==================================================

	// Renamed instructions accepted per cycle
	localparam int DECODE_WIDTH   = 2;
	// Oldest entries offered to issue per cycle
	localparam int DISPATCH_WIDTH = 2;
	// Writeback broadcast ports
	localparam int WB_WIDTH       = 2;

	// ==================================================
	// Storage sizes
	// ==================================================

	// Queue depth, kept a power of two so pointers wrap for free
	localparam int QUEUE_DEPTH = 8;
	localparam int PREG_COUNT  = 64;
	localparam int PREG_W      = 6;
	// Pointer into the queue
	localparam int PTR_W       = 3;
	// Occupancy count, one bit wider than a pointer
	localparam int CNT_W       = 4;
	localparam int OPC_W       = 8;

	// One instruction as it leaves rename
	typedef struct packed {
		logic [OPC_W-1:0]  opcode;
		logic [PREG_W-1:0] pdest;
		logic [PREG_W-1:0] src0;
		logic [PREG_W-1:0] src1;
	} rename_op_t;

	// Queued instruction, rename fields plus per-source readiness
	typedef struct packed {
		logic [OPC_W-1:0]  opcode;
		logic [PREG_W-1:0] pdest;
		logic [PREG_W-1:0] src0;
		logic [PREG_W-1:0] src1;
		logic              src0_ready;
		logic              src1_ready;
	} dq_entry_t;

	// Writeback broadcast of a produced physical register
	typedef struct packed {
		logic              valid;
		logic [PREG_W-1:0] pdest;
	} wb_tag_t;

endpackage

`default_nettype wire

// ==== logic/ready_table.sv ====
// Ready table with one bit per physical register, giving source readiness for each rename group
`timescale 1ns/10ps
`default_nettype none

module ready_table import sched_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	// Lanes already gated by the queue accept
	input  logic [DECODE_WIDTH-1:0]       alloc_valid_i,
	input  rename_op_t [DECODE_WIDTH-1:0] alloc_op_i,
	input  wb_tag_t [WB_WIDTH-1:0]        wb_i,
	// Bit 0 for src0, bit 1 for src1
	output logic [DECODE_WIDTH-1:0][1:0]  src_ready_o
);

	// Set means value available, clear means producer in flight
	logic [PREG_COUNT-1:0] ready_q;
	logic [PREG_COUNT-1:0] ready_n;
	// Registers broadcast this cycle
	logic [PREG_COUNT-1:0] wb_hit;
	// Registers claimed as destinations this cycle
	logic [PREG_COUNT-1:0] alloc_hit;

	// ==================================================
	// Decode writeback and allocation into masks
	// ==================================================

	always_comb begin
		wb_hit = '0;
		for (int w = 0; w < WB_WIDTH; w++) begin
			if (wb_i[w].valid) begin
				wb_hit[wb_i[w].pdest] = 1'b1;
			end
		end
	end

	always_comb begin
		alloc_hit = '0;
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (alloc_valid_i[i]) begin
				alloc_hit[alloc_op_i[i].pdest] = 1'b1;
			end
		end
	end

	// ==================================================
	// Source lookup for the incoming group
	// ==================================================

	always_comb begin
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			// Table bit or same-cycle writeback bypass
			src_ready_o[i][0] = ready_q[alloc_op_i[i].src0] | wb_hit[alloc_op_i[i].src0];
			src_ready_o[i][1] = ready_q[alloc_op_i[i].src1] | wb_hit[alloc_op_i[i].src1];
			// Older lane in the same group produces this source
			for (int j = 0; j < i; j++) begin
				if (alloc_valid_i[j] && (alloc_op_i[j].pdest == alloc_op_i[i].src0)) begin
					src_ready_o[i][0] = 1'b0;
				end
				if (alloc_valid_i[j] && (alloc_op_i[j].pdest == alloc_op_i[i].src1)) begin
					src_ready_o[i][1] = 1'b0;
				end
			end
		end
	end

	// ==================================================
	// Table update
	// ==================================================

	// Allocation cleared last so it wins over a writeback on the same register
	assign ready_n = (ready_q | wb_hit) & ~alloc_hit;

	// Every register starts out ready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= '1;
		end else begin
			ready_q <= ready_n;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dispatch_queue.sv ====
// Dispatch queue, in-order circular buffer with multi-lane write and read and writeback wakeup
`timescale 1ns/10ps
`default_nettype none

module dispatch_queue import sched_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	// Write side, lanes contiguous from lane 0
	input  logic [DECODE_WIDTH-1:0]         write_valid_i,
	input  dq_entry_t [DECODE_WIDTH-1:0]    write_data_i,
	output logic                            write_ready_o,
	// Read side, oldest entry on lane 0
	output logic [DISPATCH_WIDTH-1:0]       read_valid_o,
	output dq_entry_t [DISPATCH_WIDTH-1:0]  read_data_o,
	input  logic [DISPATCH_WIDTH-1:0]       read_ready_i,
	// Wakeup broadcasts
	input  wb_tag_t [WB_WIDTH-1:0]          wb_i
);

	// Entry storage
	dq_entry_t [QUEUE_DEPTH-1:0] mem_q;
	dq_entry_t [QUEUE_DEPTH-1:0] mem_n;

	// Oldest slot, next free slot, occupancy
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] cnt_q;

	// Per-lane handshakes
	logic [DECODE_WIDTH-1:0]   wr_en;
	logic [DISPATCH_WIDTH-1:0] rd_fire;
	logic [CNT_W-1:0]          wr_cnt;
	logic [CNT_W-1:0]          rd_cnt;

	// Per-lane slot addresses
	logic [DECODE_WIDTH-1:0][PTR_W-1:0]   wr_ptr;
	logic [DISPATCH_WIDTH-1:0][PTR_W-1:0] rd_ptr;

	// ==================================================
	// Handshake and lane addressing
	// ==================================================

	// Room for a full group, from the registered count only
	assign write_ready_o = (cnt_q <= CNT_W'(QUEUE_DEPTH - DECODE_WIDTH));

	// Dropped group when full
	assign wr_en   = write_valid_i & {DECODE_WIDTH{write_ready_o}};
	assign rd_fire = read_valid_o & read_ready_i;

	// Contiguous lanes, so popcount gives pointer advance
	assign wr_cnt = CNT_W'($countones(wr_en));
	assign rd_cnt = CNT_W'($countones(rd_fire));

	for (genvar i = 0; i < DECODE_WIDTH; i++) begin : g_wr_lane
		assign wr_ptr[i] = tail_q + PTR_W'(i);
	end

	// Combinational read at head+i
	for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_rd_lane
		assign rd_ptr[i]       = head_q + PTR_W'(i);
		assign read_valid_o[i] = (cnt_q > CNT_W'(i));
		assign read_data_o[i]  = mem_q[rd_ptr[i]];
	end

	// ==================================================
	// Storage next state
	// ==================================================

	always_comb begin
		mem_n = mem_q;

		// Wakeup of stored sources
		for (int e = 0; e < QUEUE_DEPTH; e++) begin
			for (int w = 0; w < WB_WIDTH; w++) begin
				if (wb_i[w].valid) begin
					if (mem_q[e].src0 == wb_i[w].pdest) begin
						mem_n[e].src0_ready = 1'b1;
					end
					if (mem_q[e].src1 == wb_i[w].pdest) begin
						mem_n[e].src1_ready = 1'b1;
					end
				end
			end
		end

		// New entries overwrite, bypass already folded in by the ready table
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (wr_en[i]) begin
				mem_n[wr_ptr[i]] = write_data_i[i];
			end
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		mem_q <= mem_n;
	end

	// ==================================================
	// Pointer and count registers
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_q + PTR_W'(rd_cnt);
			tail_q <= tail_q + PTR_W'(wr_cnt);
			cnt_q  <= cnt_q + wr_cnt - rd_cnt;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sched_dispatch_top.sv ====
// Scheduler dispatch top joining the rename group to the ready table and the dispatch queue
`timescale 1ns/10ps
`default_nettype none

module sched_dispatch_top import sched_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	// From rename
	input  logic [DECODE_WIDTH-1:0]         write_valid_i,
	input  rename_op_t [DECODE_WIDTH-1:0]   write_op_i,
	output logic                            write_ready_o,
	// To issue
	output logic [DISPATCH_WIDTH-1:0]       read_valid_o,
	output dq_entry_t [DISPATCH_WIDTH-1:0]  read_data_o,
	input  logic [DISPATCH_WIDTH-1:0]       read_ready_i,
	// Writeback broadcasts
	input  wb_tag_t [WB_WIDTH-1:0]          wb_i
);

	// Lanes that actually allocate this cycle
	logic [DECODE_WIDTH-1:0]        alloc_valid;
	logic [DECODE_WIDTH-1:0][1:0]   src_ready;
	dq_entry_t [DECODE_WIDTH-1:0]   enq_entry;

	// No busy marking for a group the queue refuses
	assign alloc_valid = write_valid_i & {DECODE_WIDTH{write_ready_o}};

	// Rename fields plus initial readiness
	always_comb begin
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			enq_entry[i].opcode     = write_op_i[i].opcode;
			enq_entry[i].pdest      = write_op_i[i].pdest;
			enq_entry[i].src0       = write_op_i[i].src0;
			enq_entry[i].src1       = write_op_i[i].src1;
			enq_entry[i].src0_ready = src_ready[i][0];
			enq_entry[i].src1_ready = src_ready[i][1];
		end
	end

	ready_table u_ready_table (
		.clk           (clk),
		.rst_n         (rst_n),
		.alloc_valid_i (alloc_valid),
		.alloc_op_i    (write_op_i),
		.wb_i          (wb_i),
		.src_ready_o   (src_ready)
	);

	dispatch_queue u_dispatch_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.write_valid_i (write_valid_i),
		.write_data_i  (enq_entry),
		.write_ready_o (write_ready_o),
		.read_valid_o  (read_valid_o),
		.read_data_o   (read_data_o),
		.read_ready_i  (read_ready_i),
		.wb_i          (wb_i)
	);

endmodule

`default_nettype wire

// ==== test/dispatch_queue_asserts.sv ====
// Dispatch queue assertions on occupancy, accept threshold and sticky source readiness
`timescale 1ns/10ps
`default_nettype none

module dispatch_queue_asserts import sched_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [CNT_W-1:0]                cnt_i,
	input  logic                            write_ready_i,
	input  logic [DISPATCH_WIDTH-1:0]       read_valid_i,
	input  logic [DISPATCH_WIDTH-1:0]       read_ready_i,
	input  dq_entry_t [DISPATCH_WIDTH-1:0]  read_data_i
);

	// ==================================================
	// Occupancy
	// ==================================================

	a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_i <= CNT_W'(QUEUE_DEPTH))
		else $error("queue count above depth");

	// Closed write side drops the group, so the count cannot grow
	a_full_block: assert property (@(posedge clk) disable iff (!rst_n)
		!write_ready_i |=> (cnt_i <= $past(cnt_i)))
		else $error("group accepted while write_ready_o low");

	// ==================================================
	// Sticky readiness of held entries
	// ==================================================

	// Head holds still while no lane is consumed
	for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_lane
		a_src0_sticky: assert property (@(posedge clk) disable iff (!rst_n)
			(read_valid_i[i] && (read_ready_i == '0) && read_data_i[i].src0_ready)
			|=> read_data_i[i].src0_ready)
			else $error("src0_ready cleared on a held entry");
		a_src1_sticky: assert property (@(posedge clk) disable iff (!rst_n)
			(read_valid_i[i] && (read_ready_i == '0) && read_data_i[i].src1_ready)
			|=> read_data_i[i].src1_ready)
			else $error("src1_ready cleared on a held entry");
	end

endmodule

bind dispatch_queue dispatch_queue_asserts u_dispatch_queue_asserts (
	.clk           (clk),
	.rst_n         (rst_n),
	.cnt_i         (cnt_q),
	.write_ready_i (write_ready_o),
	.read_valid_i  (read_valid_o),
	.read_ready_i  (read_ready_i),
	.read_data_i   (read_data_o)
);

`default_nettype wire

// ==== test/tb_sched_dispatch.sv ====
// Testbench for the scheduler dispatch slice, table-driven against a reference queue model
`timescale 1ns/10ps
`default_nettype none

module tb_sched_dispatch import sched_pkg::*; ();

	// One stimulus row, rnd lanes take a random op
	typedef struct packed {
		logic [DECODE_WIDTH-1:0]       wv;
		logic [DECODE_WIDTH-1:0]       rnd;
		rename_op_t [DECODE_WIDTH-1:0] op;
		logic [DISPATCH_WIDTH-1:0]     rr;
		wb_tag_t [WB_WIDTH-1:0]        wb;
	} row_t;

	logic                           clk;
	logic                           rst_n;
	logic [DECODE_WIDTH-1:0]        write_valid;
	rename_op_t [DECODE_WIDTH-1:0]  write_op;
	logic                           write_ready;
	logic [DISPATCH_WIDTH-1:0]      read_valid;
	dq_entry_t [DISPATCH_WIDTH-1:0] read_data;
	logic [DISPATCH_WIDTH-1:0]      read_ready;
	wb_tag_t [WB_WIDTH-1:0]         wb;

	integer                seed = 32'h7848_a90f;
	int                    errors = 0;
	row_t                  rows[$];
	// Reference model state
	dq_entry_t             model_q[$];
	logic [PREG_COUNT-1:0] model_rdy;

	sched_dispatch_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.write_valid_i (write_valid),
		.write_op_i    (write_op),
		.write_ready_o (write_ready),
		.read_valid_o  (read_valid),
		.read_data_o   (read_data),
		.read_ready_i  (read_ready),
		.wb_i          (wb)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Released on the fourth falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	end

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
			$display("Errors found");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_entry(input string name, input dq_entry_t exp, input dq_entry_t act);
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
			$display("Errors found");
			$fatal(1, "entry mismatch");
		end
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	function automatic rename_op_t build_op(input logic [OPC_W-1:0] opc,
			input logic [PREG_W-1:0] pd, input logic [PREG_W-1:0] s0, input logic [PREG_W-1:0] s1);
		rename_op_t op;
		op.opcode = opc;
		op.pdest  = pd;
		op.src0   = s0;
		op.src1   = s1;
		return op;
	endfunction

	function automatic wb_tag_t broadcast(input logic [PREG_W-1:0] pd);
		wb_tag_t t;
		t.valid = 1'b1;
		t.pdest = pd;
		return t;
	endfunction

	task automatic add_row(input logic [1:0] wv, input logic [1:0] rnd, input rename_op_t op0,
			input rename_op_t op1, input logic [1:0] rr, input wb_tag_t wb0, input wb_tag_t wb1);
		row_t r;
		r.wv    = wv;
		r.rnd   = rnd;
		r.op[0] = op0;
		r.op[1] = op1;
		r.rr    = rr;
		r.wb[0] = wb0;
		r.wb[1] = wb1;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Lane 1 reads lane 0 destination
		add_row(2'b11, 2'b00, build_op(8'h10, 6'd1, 6'd2, 6'd3),
			build_op(8'h11, 6'd4, 6'd1, 6'd5), 2'b00, '0, '0);
		// Source on a busy register
		add_row(2'b01, 2'b00, build_op(8'h12, 6'd6, 6'd4, 6'd7), '0, 2'b00, '0, '0);
		add_row(2'b00, 2'b00, '0, '0, 2'b00, broadcast(6'd4), '0);
		// Bypass at enqueue, lane 0 read only
		add_row(2'b01, 2'b00, build_op(8'h13, 6'd8, 6'd1, 6'd9), '0, 2'b01, broadcast(6'd1), '0);
		add_row(2'b11, 2'b11, '0, '0, 2'b11, '0, '0);
		add_row(2'b11, 2'b00, build_op(8'h14, 6'd10, 6'd6, 6'd8),
			build_op(8'h15, 6'd11, 6'd10, 6'd12), 2'b00, '0, '0);
		add_row(2'b11, 2'b11, '0, '0, 2'b00, '0, '0);
		// Count now 7, both groups dropped
		add_row(2'b11, 2'b00, build_op(8'h20, 6'd20, 6'd0, 6'd0),
			build_op(8'h21, 6'd21, 6'd0, 6'd0), 2'b00, '0, '0);
		add_row(2'b01, 2'b00, build_op(8'h22, 6'd22, 6'd20, 6'd21), '0, 2'b00, '0, '0);
		add_row(2'b00, 2'b00, '0, '0, 2'b01, '0, '0);
		// Dropped destinations never went busy
		add_row(2'b11, 2'b00, build_op(8'h23, 6'd23, 6'd20, 6'd21),
			build_op(8'h24, 6'd24, 6'd22, 6'd2), 2'b11, '0, '0);
		add_row(2'b00, 2'b00, '0, '0, 2'b00, broadcast(6'd6), broadcast(6'd8));
		for (int k = 0; k < 4; k++) begin
			add_row(2'b00, 2'b00, '0, '0, 2'b11, '0, '0);
		end
		// Allocation wins over writeback of register 30
		add_row(2'b01, 2'b00, build_op(8'h30, 6'd30, 6'd1, 6'd1), '0, 2'b00, broadcast(6'd30), '0);
		add_row(2'b01, 2'b00, build_op(8'h31, 6'd31, 6'd30, 6'd4), '0, 2'b01, '0, '0);
		// Mixed random traffic, then drain
		for (int k = 0; k < 6; k++) begin
			add_row(k[0] ? 2'b01 : 2'b11, 2'b11, '0, '0, k[0] ? 2'b11 : 2'b01, '0, '0);
		end
		for (int k = 0; k < 5; k++) begin
			add_row(2'b00, 2'b00, '0, '0, 2'b11, '0, '0);
		end
	endtask

	// Random destinations kept in 48..63, away from the directed registers
	task automatic random_op(output rename_op_t op);
		op.opcode = OPC_W'($random(seed));
		op.pdest  = {2'b11, 4'($random(seed))};
		op.src0   = PREG_W'($random(seed));
		op.src1   = PREG_W'($random(seed));
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	task automatic check_outputs();
		check_bit("write_ready_o", model_q.size() <= QUEUE_DEPTH - DECODE_WIDTH, write_ready);
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			check_bit($sformatf("read_valid_o[%0d]", i), model_q.size() > i, read_valid[i]);
			if (model_q.size() > i) begin
				check_entry($sformatf("read_data_o[%0d]", i), model_q[i], read_data[i]);
			end
		end
	endtask

	// One rising edge of the scheduler
	task automatic update_model(input row_t r);
		dq_entry_t             enq[$];
		dq_entry_t             ent;
		logic [PREG_COUNT-1:0] wb_set;
		logic                  accept;
		int                    pops;
		accept = (model_q.size() <= QUEUE_DEPTH - DECODE_WIDTH);
		wb_set = '0;
		for (int w = 0; w < WB_WIDTH; w++) begin
			if (r.wb[w].valid) begin
				wb_set[r.wb[w].pdest] = 1'b1;
			end
		end
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (accept && r.wv[i]) begin
				ent.opcode     = r.op[i].opcode;
				ent.pdest      = r.op[i].pdest;
				ent.src0       = r.op[i].src0;
				ent.src1       = r.op[i].src1;
				ent.src0_ready = model_rdy[ent.src0] | wb_set[ent.src0];
				ent.src1_ready = model_rdy[ent.src1] | wb_set[ent.src1];
				// Producer in an older lane of the group
				for (int j = 0; j < i; j++) begin
					if (r.wv[j] && (r.op[j].pdest == ent.src0)) ent.src0_ready = 1'b0;
					if (r.wv[j] && (r.op[j].pdest == ent.src1)) ent.src1_ready = 1'b0;
				end
				enq.push_back(ent);
			end
		end
		pops = 0;
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			if ((model_q.size() > i) && r.rr[i]) pops++;
		end
		repeat (pops) void'(model_q.pop_front());
		foreach (model_q[k]) begin
			if (wb_set[model_q[k].src0]) model_q[k].src0_ready = 1'b1;
			if (wb_set[model_q[k].src1]) model_q[k].src1_ready = 1'b1;
		end
		foreach (enq[k]) model_q.push_back(enq[k]);
		model_rdy = model_rdy | wb_set;
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (accept && r.wv[i]) model_rdy[r.op[i].pdest] = 1'b0;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin : main
		row_t r;
		int   waited;
		write_valid = '0;
		write_op    = '0;
		read_ready  = '0;
		wb          = '0;
		model_rdy   = '1;
		build_table();
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				$display("Reset was never released");
				$display("Errors found");
				$fatal(1, "reset timeout");
			end
		end
		@(negedge clk);
		// Empty queue and open write side out of reset
		#40;
		check_bit("write_ready_o", 1'b1, write_ready);
		check_bit("read_valid_o[0]", 1'b0, read_valid[0]);
		check_bit("read_valid_o[1]", 1'b0, read_valid[1]);
		@(negedge clk);
		foreach (rows[n]) begin
			r = rows[n];
			for (int i = 0; i < DECODE_WIDTH; i++) begin
				if (r.rnd[i]) random_op(r.op[i]);
			end
			write_valid = r.wv;
			write_op    = r.op;
			read_ready  = r.rr;
			wb          = r.wb;
			#40;
			check_outputs();
			update_model(r);
			@(negedge clk);
		end
		write_valid = '0;
		read_ready  = '0;
		wb          = '0;
		#40;
		check_outputs();
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sched_dispatch.f ====
logic/sched_pkg.sv
logic/ready_table.sv
logic/dispatch_queue.sv
logic/sched_dispatch_top.sv
test/dispatch_queue_asserts.sv
test/tb_sched_dispatch.sv
